//--- Makefile
TOP := tb_ooo_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- alu_fu.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module alu_fu (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb
);
    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] result;

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: result = issue.op1 + issue.op2;
            ALU_SUB: result = issue.op1 - issue.op2;
            ALU_AND: result = issue.op1 & issue.op2;
            ALU_OR:  result = issue.op1 | issue.op2;
            ALU_XOR: result = issue.op1 ^ issue.op2;
            // Signed compare
            ALU_SLT: result = {{(`OOO_XLEN - 1){1'b0}}, $signed(issue.op1) < $signed(issue.op2)};
            default: result = '0;
        endcase
    end

    // One cycle to the broadcast
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        cdb.tag   <= issue.tag;
        cdb.value <= result;
    end

endmodule

`default_nettype wire

//--- dispatch.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module dispatch (
    input  ooo_pkg::inst_u      head_inst,
    input  logic                buffer_empty,
    input  logic                rs_free,
    input  logic                rob_free,
    output logic                dispatch_fire,
    output ooo_pkg::dp_packet_t dp_packet
);
    import ooo_pkg::*;

    alu_op_e op;
    logic    f3_ok;
    logic    is_op;
    logic    is_op_imm;
    logic    sub_form;
    logic    known;

    // Stall when buffer empty or either table full
    assign dispatch_fire = !buffer_empty && rs_free && rob_free;

    //////////////////////////////
    // Decode
    //////////////////////////////

    always_comb begin
        f3_ok = 1'b1;
        // funct3 picks the operation for both groups
        case (head_inst.r.funct3)
            3'b000: op = ALU_ADD;
            3'b010: op = ALU_SLT;
            3'b100: op = ALU_XOR;
            3'b110: op = ALU_OR;
            3'b111: op = ALU_AND;
            default: begin
                op    = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase

        is_op     = (head_inst.r.opcode == `OOO_OPC_OP);
        is_op_imm = (head_inst.i.opcode == `OOO_OPC_OP_IMM);
        // SUB only exists in the register form
        sub_form  = is_op && (head_inst.r.funct7 == 7'h20) && (head_inst.r.funct3 == 3'b000);
        if (sub_form) begin
            op = ALU_SUB;
        end

        known = f3_ok && (is_op_imm || (is_op && (head_inst.r.funct7 == 7'h00 || sub_form)));
    end

    // Packet
    always_comb begin
        dp_packet.alu_op   = op;
        dp_packet.rd       = head_inst.r.rd;
        // No write for unknown words or x0
        dp_packet.has_dest = known && (head_inst.r.rd != '0);
        // Unknown words read x0 so they never wait
        dp_packet.rs1      = known ? head_inst.r.rs1 : '0;
        dp_packet.rs2      = head_inst.r.rs2;
        dp_packet.uses_rs2 = known && is_op;
        dp_packet.imm      = {{(`OOO_XLEN - 12){head_inst.i.imm12[11]}}, head_inst.i.imm12};
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
ooo_pkg.sv
insn_buffer.sv
dispatch.sv
map_table.sv
rs.sv
alu_fu.sv
rob.sv
ooo_core.sv
ooo_props.sv
tb_ooo_core.sv

//--- insn_buffer.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module insn_buffer (
    input  logic           clock,
    input  logic           reset,
    input  logic           push,
    input  ooo_pkg::inst_u push_inst,
    input  logic           pop,
    output ooo_pkg::inst_u head_inst,
    output logic           empty,
    output logic           full
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(`OOO_IB_DEPTH);
    localparam int CNT_W = $clog2(`OOO_IB_DEPTH + 1);

    // Raw words, decode happens in dispatch
    inst_u            mem [`OOO_IB_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(`OOO_IB_DEPTH));
    assign head_inst = mem[head];

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[tail] <= push_inst;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Depth is a power of two so pointers wrap on their own
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- map_table.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module map_table (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  ooo_pkg::dp_packet_t       dp_packet,
    input  logic [`OOO_ROB_TAG_W-1:0] rob_tail_tag,
    input  ooo_pkg::retire_t          retire,
    output logic                      rs1_busy,
    output logic                      rs2_busy,
    output logic [`OOO_ROB_TAG_W-1:0] rs1_tag,
    output logic [`OOO_ROB_TAG_W-1:0] rs2_tag,
    output logic [`OOO_XLEN-1:0]      rs1_value,
    output logic [`OOO_XLEN-1:0]      rs2_value
);
    localparam int NREG = 1 << `OOO_REG_IDX_W;

    // Rename state per architectural register
    logic [NREG-1:0]           busy;
    logic [`OOO_ROB_TAG_W-1:0] tag  [NREG];
    // Committed values
    logic [`OOO_XLEN-1:0]      regs [NREG];

    logic rename;

    assign rename = dispatch_fire && dp_packet.has_dest;

    // Lookup uses state before this cycle's rename
    assign rs1_busy  = busy[dp_packet.rs1];
    assign rs2_busy  = busy[dp_packet.rs2];
    assign rs1_tag   = tag[dp_packet.rs1];
    assign rs2_tag   = tag[dp_packet.rs2];
    // x0 hardwired
    assign rs1_value = (dp_packet.rs1 == '0) ? '0 : regs[dp_packet.rs1];
    assign rs2_value = (dp_packet.rs2 == '0) ? '0 : regs[dp_packet.rs2];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (retire.valid && retire.has_dest) begin
                regs[retire.rd] <= retire.value;
                // Only the latest producer frees the register
                if (tag[retire.rd] == retire.tag) begin
                    busy[retire.rd] <= 1'b0;
                end
            end
            // Later assignment so a new rename wins
            if (rename) begin
                busy[dp_packet.rd] <= 1'b1;
            end
        end
    end

    // Tags
    always_ff @(posedge clock) begin
        if (rename) begin
            tag[dp_packet.rd] <= rob_tail_tag;
        end
    end

endmodule

`default_nettype wire

//--- ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Structure depths
`define OOO_IB_DEPTH   4
`define OOO_RS_DEPTH   4
`define OOO_ROB_DEPTH  8
`define OOO_ROB_TAG_W  3

// Datapath widths
`define OOO_XLEN       32
`define OOO_REG_IDX_W  5

// RV32I major opcodes
`define OOO_OPC_OP     7'b0110011
`define OOO_OPC_OP_IMM 7'b0010011

`endif

//--- ooo_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  ooo_pkg::inst_u            inst,
    output logic                      inst_ready,
    output logic                      commit_valid,
    output logic                      commit_wr_en,
    output logic [`OOO_REG_IDX_W-1:0] commit_wr_idx,
    output logic [`OOO_XLEN-1:0]      commit_wr_data
);
    import ooo_pkg::*;

    //////////////////////////////
    // Stage wires
    //////////////////////////////

    // Buffer to dispatch
    inst_u      head_inst;
    logic       ib_empty;
    logic       ib_full;

    // Dispatch
    dp_packet_t dp_packet;
    logic       dispatch_fire;
    logic       rs_free;
    logic       rob_free;
    logic [`OOO_ROB_TAG_W-1:0] rob_tail_tag;

    // Map lookup
    logic                      rs1_busy;
    logic                      rs2_busy;
    logic [`OOO_ROB_TAG_W-1:0] rs1_tag;
    logic [`OOO_ROB_TAG_W-1:0] rs2_tag;
    logic [`OOO_XLEN-1:0]      rs1_value;
    logic [`OOO_XLEN-1:0]      rs2_value;

    // ROB lookup
    logic                 rob1_done;
    logic                 rob2_done;
    logic [`OOO_XLEN-1:0] rob1_value;
    logic [`OOO_XLEN-1:0] rob2_value;

    // Execute and retire
    issue_t  issue;
    cdb_t    cdb;
    retire_t retire;

    // Accept while the buffer has room
    assign inst_ready = !ib_full;

    insn_buffer u_insn_buffer (
        .clock     (clock),
        .reset     (reset),
        .push      (inst_valid && inst_ready),
        .push_inst (inst),
        .pop       (dispatch_fire),
        .head_inst (head_inst),
        .empty     (ib_empty),
        .full      (ib_full)
    );

    dispatch u_dispatch (
        .head_inst     (head_inst),
        .buffer_empty  (ib_empty),
        .rs_free       (rs_free),
        .rob_free      (rob_free),
        .dispatch_fire (dispatch_fire),
        .dp_packet     (dp_packet)
    );

    map_table u_map_table (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dp_packet     (dp_packet),
        .rob_tail_tag  (rob_tail_tag),
        .retire        (retire),
        .rs1_busy      (rs1_busy),
        .rs2_busy      (rs2_busy),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value)
    );

    rs u_rs (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dp_packet     (dp_packet),
        .rob_tail_tag  (rob_tail_tag),
        .rs1_busy      (rs1_busy),
        .rs1_tag       (rs1_tag),
        .rs1_value     (rs1_value),
        .rs2_busy      (rs2_busy),
        .rs2_tag       (rs2_tag),
        .rs2_value     (rs2_value),
        .rob1_done     (rob1_done),
        .rob1_value    (rob1_value),
        .rob2_done     (rob2_done),
        .rob2_value    (rob2_value),
        .cdb           (cdb),
        .rs_free       (rs_free),
        .issue         (issue)
    );

    alu_fu u_alu_fu (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

    // Map tags index the ROB directly
    rob u_rob (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dp_packet     (dp_packet),
        .cdb           (cdb),
        .lookup1_tag   (rs1_tag),
        .lookup2_tag   (rs2_tag),
        .rob1_done     (rob1_done),
        .rob1_value    (rob1_value),
        .rob2_done     (rob2_done),
        .rob2_value    (rob2_value),
        .rob_free      (rob_free),
        .tail_tag      (rob_tail_tag),
        .retire        (retire)
    );

    // Commit port
    assign commit_valid   = retire.valid;
    assign commit_wr_en   = retire.valid && retire.has_dest;
    assign commit_wr_idx  = retire.rd;
    assign commit_wr_data = retire.value;

endmodule

`default_nettype wire

//--- ooo_pkg.sv
`default_nettype none
`include "ooo_consts.svh"

package ooo_pkg;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    // Register-register form
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`OOO_REG_IDX_W-1:0] rs2;
        logic [`OOO_REG_IDX_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [6:0]                opcode;
    } inst_r_t;

    // Register-immediate form
    typedef struct packed {
        logic [11:0]               imm12;
        logic [`OOO_REG_IDX_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [6:0]                opcode;
    } inst_i_t;

    // Same 32 bits, two decodes
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    //////////////////////////////
    // Pipeline packets
    //////////////////////////////

    // Decoded instruction handed to RS, ROB and map table
    typedef struct packed {
        alu_op_e                   alu_op;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic                      has_dest;
        logic [`OOO_REG_IDX_W-1:0] rs1;
        logic [`OOO_REG_IDX_W-1:0] rs2;
        logic                      uses_rs2;
        logic [`OOO_XLEN-1:0]      imm;
    } dp_packet_t;

    // Source operand, value valid once ready
    typedef struct packed {
        logic                      ready;
        logic [`OOO_ROB_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]      value;
    } operand_t;

    // Result broadcast
    typedef struct packed {
        logic                      valid;
        logic [`OOO_ROB_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]      value;
    } cdb_t;

    // RS to ALU
    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic [`OOO_XLEN-1:0]      op1;
        logic [`OOO_XLEN-1:0]      op2;
        logic [`OOO_ROB_TAG_W-1:0] tag;
    } issue_t;

    // ROB head leaving the machine
    typedef struct packed {
        logic                      valid;
        logic [`OOO_ROB_TAG_W-1:0] tag;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic                      has_dest;
        logic [`OOO_XLEN-1:0]      value;
    } retire_t;

endpackage

`default_nettype wire

//--- ooo_props.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_props (
    input logic                      clock,
    input logic                      reset,
    input logic                      inst_ready,
    input logic                      commit_valid,
    input logic                      commit_wr_en,
    input logic [`OOO_REG_IDX_W-1:0] commit_wr_idx
);

    // Write enable only alongside a commit
    wr_en_needs_valid: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> commit_valid)
        else $error("commit_wr_en high without commit_valid");

    // Handshake and commit flags always driven
    flags_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown({inst_ready, commit_valid}))
        else $error("inst_ready or commit_valid unknown");

    // Empty machine right after reset
    quiet_after_reset: assert property (@(posedge clock)
        reset |=> !commit_valid)
        else $error("commit_valid high in the cycle after reset");

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> (commit_wr_idx != '0))
        else $error("commit write to x0");

endmodule

`default_nettype wire

//--- rob.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  ooo_pkg::dp_packet_t       dp_packet,
    input  ooo_pkg::cdb_t             cdb,
    input  logic [`OOO_ROB_TAG_W-1:0] lookup1_tag,
    input  logic [`OOO_ROB_TAG_W-1:0] lookup2_tag,
    output logic                      rob1_done,
    output logic [`OOO_XLEN-1:0]      rob1_value,
    output logic                      rob2_done,
    output logic [`OOO_XLEN-1:0]      rob2_value,
    output logic                      rob_free,
    output logic [`OOO_ROB_TAG_W-1:0] tail_tag,
    output ooo_pkg::retire_t          retire
);
    localparam int D     = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(D + 1);

    logic [`OOO_ROB_TAG_W-1:0] head;
    logic [`OOO_ROB_TAG_W-1:0] tail;
    logic [CNT_W-1:0]          count;
    logic [D-1:0]              done;

    // Per-entry payload
    logic [`OOO_REG_IDX_W-1:0] rd    [D];
    logic [D-1:0]              has_dest;
    logic [`OOO_XLEN-1:0]      value [D];

    logic retire_fire;

    // Head leaves once its result is in
    assign retire_fire = (count != '0) && done[head];
    assign rob_free    = (count != CNT_W'(D));
    assign tail_tag    = tail;

    // Forwarding to dispatch
    assign rob1_done  = done[lookup1_tag];
    assign rob1_value = value[lookup1_tag];
    assign rob2_done  = done[lookup2_tag];
    assign rob2_value = value[lookup2_tag];

    always_comb begin
        retire.valid    = retire_fire;
        retire.tag      = head;
        retire.rd       = rd[head];
        retire.has_dest = has_dest[head];
        retire.value    = value[head];
    end

    //////////////////////////////
    // Control state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            // Tag width matches depth so pointers wrap
            if (dispatch_fire) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            // Tail is free so never the CDB tag
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire_fire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(dispatch_fire) - CNT_W'(retire_fire);
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            rd[tail]       <= dp_packet.rd;
            has_dest[tail] <= dp_packet.has_dest;
        end
        if (cdb.valid) begin
            value[cdb.tag] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

//--- rs.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rs (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  ooo_pkg::dp_packet_t       dp_packet,
    input  logic [`OOO_ROB_TAG_W-1:0] rob_tail_tag,
    input  logic                      rs1_busy,
    input  logic [`OOO_ROB_TAG_W-1:0] rs1_tag,
    input  logic [`OOO_XLEN-1:0]      rs1_value,
    input  logic                      rs2_busy,
    input  logic [`OOO_ROB_TAG_W-1:0] rs2_tag,
    input  logic [`OOO_XLEN-1:0]      rs2_value,
    input  logic                      rob1_done,
    input  logic [`OOO_XLEN-1:0]      rob1_value,
    input  logic                      rob2_done,
    input  logic [`OOO_XLEN-1:0]      rob2_value,
    input  ooo_pkg::cdb_t             cdb,
    output logic                      rs_free,
    output ooo_pkg::issue_t           issue
);
    import ooo_pkg::*;

    localparam int N = `OOO_RS_DEPTH;

    logic [N-1:0]              valid;
    alu_op_e                   op    [N];
    operand_t                  src1  [N];
    operand_t                  src2  [N];
    logic [`OOO_ROB_TAG_W-1:0] dest  [N];
    // older[i][j] set when entry i arrived before entry j
    logic [N-1:0]              older [N];

    logic [N-1:0] ready;
    logic [N-1:0] grant;
    logic [N-1:0] free_sel;
    operand_t     new1;
    operand_t     new2;

    // Map value, ROB value or same-cycle broadcast
    function automatic operand_t resolve(
        input logic                      busy,
        input logic [`OOO_ROB_TAG_W-1:0] tag,
        input logic [`OOO_XLEN-1:0]      value,
        input logic                      done,
        input logic [`OOO_XLEN-1:0]      rob_value,
        input cdb_t                      bus
    );
        operand_t o;
        o.ready = 1'b1;
        o.tag   = tag;
        o.value = value;
        if (busy) begin
            if (bus.valid && bus.tag == tag) begin
                o.value = bus.value;
            end else if (done) begin
                o.value = rob_value;
            end else begin
                o.ready = 1'b0;
            end
        end
        return o;
    endfunction

    //////////////////////////////
    // Dispatch side
    //////////////////////////////

    always_comb begin
        new1 = resolve(rs1_busy, rs1_tag, rs1_value, rob1_done, rob1_value, cdb);
        new2 = resolve(rs2_busy, rs2_tag, rs2_value, rob2_done, rob2_value, cdb);
        // I-type second operand
        if (!dp_packet.uses_rs2) begin
            new2.ready = 1'b1;
            new2.value = dp_packet.imm;
        end
    end

    // Lowest free slot
    always_comb begin
        free_sel = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    assign rs_free = !(&valid);

    //////////////////////////////
    // Issue select
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ready[i] = valid[i] && src1[i].ready && src2[i].ready;
        end
        // Drop any candidate with an older ready entry
        for (int i = 0; i < N; i++) begin
            grant[i] = ready[i];
            for (int j = 0; j < N; j++) begin
                if (j != i && ready[j] && older[j][i]) begin
                    grant[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        issue = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                issue.valid  = 1'b1;
                issue.alu_op = op[i];
                issue.op1    = src1[i].value;
                issue.op2    = src2[i].value;
                issue.tag    = dest[i];
            end
        end
    end

    // Occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~grant) | (dispatch_fire ? free_sel : '0);
        end
    end

    // Entry fill, wakeup and age order
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (dispatch_fire && free_sel[i]) begin
                op[i]    <= dp_packet.alu_op;
                src1[i]  <= new1;
                src2[i]  <= new2;
                dest[i]  <= rob_tail_tag;
                older[i] <= '0;
            end else begin
                if (cdb.valid && !src1[i].ready && src1[i].tag == cdb.tag) begin
                    src1[i].ready <= 1'b1;
                    src1[i].value <= cdb.value;
                end
                if (cdb.valid && !src2[i].ready && src2[i].tag == cdb.tag) begin
                    src2[i].ready <= 1'b1;
                    src2[i].value <= cdb.value;
                end
                // Everything present is older than the newcomer
                if (dispatch_fire) begin
                    older[i] <= older[i] | free_sel;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_ooo_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int N_INSTS     = 400;
    // Worst case is well under 20 cycles per instruction
    localparam int CYCLE_LIMIT = N_INSTS * 20;

    // One expected commit
    typedef struct packed {
        logic                      has_dest;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [`OOO_XLEN-1:0]      value;
    } expect_t;

    logic                      clock;
    logic                      reset;
    logic                      inst_valid;
    inst_u                     inst;
    logic                      inst_ready;
    logic                      commit_valid;
    logic                      commit_wr_en;
    logic [`OOO_REG_IDX_W-1:0] commit_wr_idx;
    logic [`OOO_XLEN-1:0]      commit_wr_data;

    expect_t                   exp_q[$];
    logic [31:0][`OOO_XLEN-1:0] model_regs;
    int                        accepted;
    int                        generated;
    int                        commits;
    int                        cycles;
    logic [`OOO_REG_IDX_W-1:0] last_rd;

    ooo_core dut (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data)
    );

    bind ooo_core ooo_props u_props (
        .clock         (clock),
        .reset         (reset),
        .inst_ready    (inst_ready),
        .commit_valid  (commit_valid),
        .commit_wr_en  (commit_wr_en),
        .commit_wr_idx (commit_wr_idx)
    );

    always #5 clock = ~clock;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic value_mismatch(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "%s", msg);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Architectural result of one word in program order
    function automatic void reference_result(
        input  inst_u                      w,
        inout  logic [31:0][`OOO_XLEN-1:0] regs,
        output expect_t                    e
    );
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        logic                 is_r;
        logic                 is_i;
        logic                 known;
        is_r    = (w.r.opcode == `OOO_OPC_OP);
        is_i    = (w.r.opcode == `OOO_OPC_OP_IMM);
        a       = regs[w.r.rs1];
        b       = is_r ? regs[w.r.rs2] : {{20{w.i.imm12[11]}}, w.i.imm12};
        known   = is_r || is_i;
        e.value = '0;
        case (w.r.funct3)
            3'b000: e.value = (is_r && w.r.funct7 == 7'h20) ? a - b : a + b;
            3'b010: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: e.value = a ^ b;
            3'b110: e.value = a | b;
            3'b111: e.value = a & b;
            default: known = 1'b0;
        endcase
        // Register form only allows funct7 zero or SUB
        if (is_r && !(w.r.funct7 == 7'h00 || (w.r.funct7 == 7'h20 && w.r.funct3 == 3'b000))) begin
            known = 1'b0;
        end
        e.rd       = w.r.rd;
        e.has_dest = known && (w.r.rd != '0);
        if (e.has_dest) begin
            regs[w.r.rd] = e.value;
        end
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    function automatic logic [2:0] pick_funct3();
        case ($urandom % 5)
            0: return 3'b000;
            1: return 3'b010;
            2: return 3'b100;
            3: return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    // Small register pool and reuse of the last rd give long dependency chains
    function automatic inst_u random_word(input logic [`OOO_REG_IDX_W-1:0] prev_rd);
        inst_r_t r;
        inst_u   w;
        int      kind;
        kind     = int'($urandom % 16);
        r.rd     = 5'($urandom % 8);
        r.rs1    = ($urandom % 2 == 0) ? prev_rd : 5'($urandom % 8);
        r.rs2    = ($urandom % 3 == 0) ? prev_rd : 5'($urandom % 8);
        r.funct3 = pick_funct3();
        r.funct7 = 7'h00;
        r.opcode = `OOO_OPC_OP;
        if (kind < 7) begin
            // SUB on half of the funct3 000 cases
            if (r.funct3 == 3'b000 && $urandom % 2 == 1) begin
                r.funct7 = 7'h20;
            end
        end else if (kind < 12) begin
            // I-type word with imm12 over funct7 and rs2
            r.opcode          = `OOO_OPC_OP_IMM;
            {r.funct7, r.rs2} = 12'($urandom);
        end else if (kind == 12) begin
            // Load opcode is unsupported
            r.opcode          = 7'b0000011;
            {r.funct7, r.rs2} = 12'($urandom);
        end else if (kind == 13) begin
            r.funct3 = 3'b001;
        end else if (kind == 14) begin
            r.funct7 = 7'h01;
        end else begin
            r.rd = '0;
        end
        w.r = r;
        return w;
    endfunction

    initial begin
        expect_t e;
        inst_u   next_word;
        clock      = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        model_regs = '0;
        accepted   = 0;
        generated  = 0;
        last_rd    = '0;
        void'($urandom(32'hb66e44ab));
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (accepted < N_INSTS) begin
            @(posedge clock);
            // Word taken at this edge
            if (inst_valid && inst_ready) begin
                reference_result(inst, model_regs, e);
                exp_q.push_back(e);
                accepted++;
            end
            // Hold the word while stalled
            if (!inst_valid || inst_ready) begin
                // Middle stretch is a gapless burst that fills the ROB
                if (generated < N_INSTS &&
                    ((generated >= 150 && generated < 300) || $urandom % 3 != 0)) begin
                    next_word   = random_word(last_rd);
                    inst_valid <= 1'b1;
                    inst       <= next_word;
                    last_rd    <= next_word.r.rd;
                    generated++;
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end
        inst_valid <= 1'b0;
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    initial begin
        commits = 0;
        cycles  = 0;
    end

    always @(posedge clock) begin
        expect_t e;
        if (!reset && commit_valid) begin
            assert (exp_q.size() > 0) else begin
                abort_run("Commit seen with no accepted instruction outstanding");
            end
            e = exp_q.pop_front();
            commits++;
            assert (commit_wr_en == e.has_dest) else begin
                value_mismatch($sformatf("commit %0d wr_en %0b, expected %0b",
                                         commits, commit_wr_en, e.has_dest));
            end
            if (e.has_dest) begin
                assert (commit_wr_idx == e.rd) else begin
                    value_mismatch($sformatf("commit %0d wr_idx %0d, expected %0d",
                                             commits, commit_wr_idx, e.rd));
                end
                assert (commit_wr_data == e.value) else begin
                    value_mismatch($sformatf("commit %0d x%0d data %h, expected %h",
                                             commits, e.rd, commit_wr_data, e.value));
                end
            end
        end
    end

    // Cycle budget
    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        @(negedge reset);
        while (commits < N_INSTS) begin
            @(posedge clock);
        end
        // Idle tail so stray commits are caught
        repeat (10) @(posedge clock);
        if (exp_q.size() == 0 && accepted == N_INSTS) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("Expected commits left over at the end of the run");
        end
    end

endmodule

`default_nettype wire
